//--- logic/rv_decode_pkg.sv
package rv_decode_pkg;

    typedef logic [63:0] xlen_t;     // data / address word
    typedef logic [4:0]  reg_addr_t; // x0..x31
    typedef logic [31:0] inst_t;

    localparam int SHAMT_W = 6; // rv64 shift amount

    // major opcodes handled by the decode stage
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_OP_IMM_W = 7'b0011011,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_OP_W     = 7'b0111011,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT // inst[25:20], zero extended
    } imm_fmt_e;

    typedef enum logic [1:0] {
        OP1_ZERO,
        OP1_RS1,
        OP1_PC
    } op1_sel_e;

    typedef enum logic [2:0] {
        OP2_ZERO,
        OP2_RS2,
        OP2_RS2_SHAMT, // rs2[5:0] only
        OP2_IMM,
        OP2_FOUR       // link value pc + 4
    } op2_sel_e;

    typedef enum logic [1:0] {
        BASE_ZERO,
        BASE_PC,
        BASE_RS1
    } base_sel_e;

    // decoder output, all zero for an illegal encoding
    typedef struct packed {
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        logic      reg_wen;
        imm_fmt_e  imm_fmt;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        base_sel_e base_sel;
        logic      offset_en; // offset = immediate when set
    } decode_ctrl_t;

    // bundle handed to the execute stage
    typedef struct packed {
        inst_t     inst;
        xlen_t     inst_addr;
        xlen_t     op1;
        xlen_t     op2;
        reg_addr_t rd_addr;
        logic      reg_wen;
        xlen_t     base_addr;
        xlen_t     offset_addr;
    } id_ex_t;

endpackage

//--- logic/inst_decoder.sv
module inst_decoder import rv_decode_pkg::*; (
    input  inst_t        inst_i,
    output decode_ctrl_t ctrl_o
);

    opcode_e    opcode;
    logic [2:0] func3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic       is_shift; // func3 001 or 101

    assign opcode   = opcode_e'(inst_i[6:0]);
    assign func3    = inst_i[14:12];
    assign rs1      = inst_i[19:15];
    assign rs2      = inst_i[24:20];
    assign rd       = inst_i[11:7];
    assign is_shift = (func3[1:0] == 2'b01);

    always_comb begin
        ctrl_o = '0; // unknown encodings stay all zero
        case (opcode)
            OPC_OP_IMM: begin
                ctrl_o.rs1_addr = rs1;
                ctrl_o.rd_addr  = rd;
                ctrl_o.reg_wen  = 1'b1;
                ctrl_o.op1_sel  = OP1_RS1;
                ctrl_o.op2_sel  = OP2_IMM;
                ctrl_o.imm_fmt  = is_shift ? IMM_SHAMT : IMM_I;
            end
            OPC_OP_IMM_W: begin
                if (func3 == 3'b000 || is_shift) begin // addiw, slliw, srliw/sraiw
                    ctrl_o.rs1_addr = rs1;
                    ctrl_o.rd_addr  = rd;
                    ctrl_o.reg_wen  = 1'b1;
                    ctrl_o.op1_sel  = OP1_RS1;
                    ctrl_o.op2_sel  = OP2_IMM;
                    ctrl_o.imm_fmt  = is_shift ? IMM_SHAMT : IMM_I;
                end
            end
            OPC_OP: begin
                ctrl_o.rs1_addr = rs1;
                ctrl_o.rs2_addr = rs2;
                ctrl_o.rd_addr  = rd;
                ctrl_o.reg_wen  = 1'b1;
                ctrl_o.op1_sel  = OP1_RS1;
                ctrl_o.op2_sel  = is_shift ? OP2_RS2_SHAMT : OP2_RS2;
            end
            OPC_OP_W: begin
                // addw/subw, sllw, srlw/sraw
                if (func3 == 3'b000 || is_shift) begin
                    ctrl_o.rs1_addr = rs1;
                    ctrl_o.rs2_addr = rs2;
                    ctrl_o.rd_addr  = rd;
                    ctrl_o.reg_wen  = 1'b1;
                    ctrl_o.op1_sel  = OP1_RS1;
                    ctrl_o.op2_sel  = OP2_RS2;
                end
            end
            OPC_BRANCH: begin
                if (func3[2:1] != 2'b01) begin // 010 and 011 are reserved
                    ctrl_o.rs1_addr  = rs1;
                    ctrl_o.rs2_addr  = rs2;
                    ctrl_o.op1_sel   = OP1_RS1;
                    ctrl_o.op2_sel   = OP2_RS2;
                    ctrl_o.imm_fmt   = IMM_B;
                    ctrl_o.base_sel  = BASE_PC;
                    ctrl_o.offset_en = 1'b1;
                end
            end
            OPC_LOAD: begin
                if (func3 != 3'b111) begin // lb .. lwu
                    ctrl_o.rs1_addr  = rs1;
                    ctrl_o.rd_addr   = rd;
                    ctrl_o.reg_wen   = 1'b1;
                    ctrl_o.op1_sel   = OP1_RS1;
                    ctrl_o.op2_sel   = OP2_IMM;
                    ctrl_o.imm_fmt   = IMM_I;
                    ctrl_o.base_sel  = BASE_RS1;
                    ctrl_o.offset_en = 1'b1;
                end
            end
            OPC_STORE: begin
                if (!func3[2]) begin // sb, sh, sw, sd
                    ctrl_o.rs1_addr  = rs1;
                    ctrl_o.rs2_addr  = rs2;
                    ctrl_o.op2_sel   = OP2_RS2; // store data
                    ctrl_o.imm_fmt   = IMM_S;
                    ctrl_o.base_sel  = BASE_RS1;
                    ctrl_o.offset_en = 1'b1;
                end
            end
            OPC_JAL, OPC_JALR: begin
                ctrl_o.rd_addr   = rd;
                ctrl_o.reg_wen   = 1'b1;
                ctrl_o.op1_sel   = OP1_PC;
                ctrl_o.op2_sel   = OP2_FOUR;
                ctrl_o.offset_en = 1'b1;
                if (opcode == OPC_JALR) begin
                    ctrl_o.rs1_addr = rs1;
                    ctrl_o.imm_fmt  = IMM_I;
                    ctrl_o.base_sel = BASE_RS1;
                end else begin
                    ctrl_o.imm_fmt  = IMM_J;
                    ctrl_o.base_sel = BASE_PC;
                end
            end
            OPC_LUI: begin
                ctrl_o.rd_addr = rd;
                ctrl_o.reg_wen = 1'b1;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.imm_fmt = IMM_U;
            end
            OPC_AUIPC: begin
                ctrl_o.rd_addr   = rd;
                ctrl_o.reg_wen   = 1'b1;
                ctrl_o.op1_sel   = OP1_PC;
                ctrl_o.op2_sel   = OP2_IMM;
                ctrl_o.imm_fmt   = IMM_U;
                ctrl_o.offset_en = 1'b1; // base stays zero
            end
            default: ;
        endcase

        // only lui writes rd with a zero op1
        assert (!ctrl_o.reg_wen || ctrl_o.op1_sel != OP1_ZERO || opcode == OPC_LUI)
            else $error("decoder sets reg_wen with op1 tied to zero, inst %h", inst_i);
    end

endmodule

//--- logic/imm_gen.sv
module imm_gen import rv_decode_pkg::*; (
    input  inst_t    inst_i,
    input  imm_fmt_e imm_fmt_i,
    output xlen_t    imm_o
);

    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (imm_fmt_i)
            IMM_I: begin
                imm_o = {{52{sign}}, inst_i[31:20]};
            end
            IMM_S: begin
                imm_o = {{52{sign}}, inst_i[31:25], inst_i[11:7]};
            end
            IMM_B: begin // bit 0 always clear
                imm_o = {{52{sign}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {{32{sign}}, inst_i[31:12], 12'b0};
            end
            IMM_J: begin
                imm_o = {{44{sign}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            end
            IMM_SHAMT: begin
                // unsigned, no sign extension
                imm_o = {{(64 - SHAMT_W){1'b0}}, inst_i[20 +: SHAMT_W]};
            end
            default: begin // IMM_NONE
                imm_o = '0;
            end
        endcase
    end

endmodule

//--- logic/reg_file.sv
module reg_file import rv_decode_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    input  logic      wb_wen_i,
    input  reg_addr_t wb_addr_i,
    input  xlen_t     wb_data_i
);

    xlen_t regs [1:31]; // no storage behind x0

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wen_i && wb_addr_i != '0) begin // writes to x0 dropped
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // no bypass, a same-cycle write shows up next cycle
    always_comb begin
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (rs1_addr_i != '0) begin
            rs1_data_o = regs[rs1_addr_i];
        end
        if (rs2_addr_i != '0) begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

    // x0 must read zero whatever was written to it
    a_x0_rs1: assert property (@(posedge clk) disable iff (reset_i)
        (rs1_addr_i == '0) |-> (rs1_data_o == '0))
        else $error("x0 read on port 1 returned nonzero data");

    a_x0_rs2: assert property (@(posedge clk) disable iff (reset_i)
        (rs2_addr_i == '0) |-> (rs2_data_o == '0))
        else $error("x0 read on port 2 returned nonzero data");

endmodule

//--- logic/operand_select.sv
module operand_select import rv_decode_pkg::*; (
    input  decode_ctrl_t ctrl_i,
    input  inst_t        inst_i,
    input  xlen_t        inst_addr_i,
    input  xlen_t        imm_i,
    input  xlen_t        rs1_data_i,
    input  xlen_t        rs2_data_i,
    output id_ex_t       bundle_o
);

    always_comb begin
        bundle_o.inst      = inst_i;
        bundle_o.inst_addr = inst_addr_i;
        bundle_o.rd_addr   = ctrl_i.rd_addr;
        bundle_o.reg_wen   = ctrl_i.reg_wen;

        case (ctrl_i.op1_sel)
            OP1_RS1: bundle_o.op1 = rs1_data_i;
            OP1_PC:  bundle_o.op1 = inst_addr_i; // jal/jalr link, auipc
            default: bundle_o.op1 = '0;
        endcase

        case (ctrl_i.op2_sel)
            OP2_RS2: begin
                bundle_o.op2 = rs2_data_i;
            end
            OP2_RS2_SHAMT: begin // register shifts use rs2[5:0]
                bundle_o.op2 = {{(64 - SHAMT_W){1'b0}}, rs2_data_i[SHAMT_W-1:0]};
            end
            OP2_IMM: begin
                bundle_o.op2 = imm_i;
            end
            OP2_FOUR: begin
                bundle_o.op2 = 64'd4;
            end
            default: begin
                bundle_o.op2 = '0;
            end
        endcase

        case (ctrl_i.base_sel)
            BASE_PC:  bundle_o.base_addr = inst_addr_i;
            BASE_RS1: bundle_o.base_addr = rs1_data_i;
            default:  bundle_o.base_addr = '0;
        endcase

        bundle_o.offset_addr = ctrl_i.offset_en ? imm_i : '0;
    end

endmodule

//--- logic/id_ex_reg.sv
module id_ex_reg import rv_decode_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  logic   valid_i,
    input  id_ex_t bundle_i,
    output logic   valid_o,
    output id_ex_t bundle_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i; // one pulse per strobe
        end
    end

    // holds the last bundle while idle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bundle_o <= '0;
        end else if (valid_i) begin
            bundle_o <= bundle_i;
        end
    end

    // every strobe gives exactly one output pulse on the next cycle
    a_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        valid_o == $past(valid_i))
        else $error("output strobe does not follow the input strobe by one cycle");

endmodule

//--- logic/decode_stage.sv
module decode_stage import rv_decode_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,

    // fetch side, single-cycle strobe
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    input  xlen_t     inst_addr_i,

    // writeback port
    input  logic      wb_wen_i,
    input  reg_addr_t wb_addr_i,
    input  xlen_t     wb_data_i,

    // to execute
    output logic      out_valid_o,
    output id_ex_t    id_ex_o
);

    decode_ctrl_t ctrl;
    xlen_t        imm;
    xlen_t        rs1_data;
    xlen_t        rs2_data;
    id_ex_t       bundle; // combinational, before the pipeline register

    inst_decoder u_inst_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    imm_gen u_imm_gen (
        .inst_i    (inst_i),
        .imm_fmt_i (ctrl.imm_fmt),
        .imm_o     (imm)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (ctrl.rs1_addr),
        .rs2_addr_i (ctrl.rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_wen_i   (wb_wen_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i)
    );

    operand_select u_operand_select (
        .ctrl_i      (ctrl),
        .inst_i      (inst_i),
        .inst_addr_i (inst_addr_i),
        .imm_i       (imm),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .bundle_o    (bundle)
    );

    id_ex_reg u_id_ex_reg (
        .clk      (clk),
        .reset_i  (reset_i),
        .valid_i  (inst_valid_i),
        .bundle_i (bundle),
        .valid_o  (out_valid_o),
        .bundle_o (id_ex_o)
    );

endmodule

//--- include/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected ID/EX bundle for one instruction
// regs mirrors the register file
function automatic id_ex_t decode_model(inst_t inst, xlen_t pc, xlen_t regs [32]);
    id_ex_t     exp;
    logic [2:0] f3;
    xlen_t      r1;
    xlen_t      r2;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    xlen_t      shamt;
    logic       shift;

    f3    = inst[14:12];
    shift = (f3 == 3'b001) || (f3 == 3'b101);
    r1    = (inst[19:15] == 5'd0) ? '0 : regs[inst[19:15]]; // x0 reads zero
    r2    = (inst[24:20] == 5'd0) ? '0 : regs[inst[24:20]];
    imm_i = xlen_t'($signed(inst[31:20]));
    imm_s = xlen_t'($signed({inst[31:25], inst[11:7]}));
    imm_b = xlen_t'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
    imm_u = xlen_t'($signed({inst[31:12], 12'b0}));
    imm_j = xlen_t'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
    shamt = xlen_t'(inst[25:20]);

    exp           = '0;
    exp.inst      = inst;
    exp.inst_addr = pc;

    case (opcode_e'(inst[6:0]))
        OPC_OP_IMM: begin
            exp.op1 = r1;
            exp.op2 = shift ? shamt : imm_i;
            exp.reg_wen = 1'b1;
        end
        OPC_OP_IMM_W: begin
            if (f3 == 3'b000 || shift) begin
                exp.op1 = r1;
                exp.op2 = shift ? shamt : imm_i;
                exp.reg_wen = 1'b1;
            end
        end
        OPC_OP: begin
            exp.op1 = r1;
            exp.op2 = shift ? {58'b0, r2[5:0]} : r2;
            exp.reg_wen = 1'b1;
        end
        OPC_OP_W: begin
            if (f3 == 3'b000 || shift) begin
                exp.op1 = r1;
                exp.op2 = r2;
                exp.reg_wen = 1'b1;
            end
        end
        OPC_BRANCH: begin
            if (f3 != 3'b010 && f3 != 3'b011) begin
                exp.op1 = r1;
                exp.op2 = r2;
                exp.base_addr = pc;
                exp.offset_addr = imm_b;
            end
        end
        OPC_LOAD: begin
            if (f3 != 3'b111) begin
                exp.op1 = r1;
                exp.op2 = imm_i;
                exp.reg_wen = 1'b1;
                exp.base_addr = r1;
                exp.offset_addr = imm_i;
            end
        end
        OPC_STORE: begin
            if (!f3[2]) begin
                exp.op2 = r2;
                exp.base_addr = r1;
                exp.offset_addr = imm_s;
            end
        end
        OPC_JAL: begin
            exp.op1 = pc;
            exp.op2 = 64'd4;
            exp.reg_wen = 1'b1;
            exp.base_addr = pc;
            exp.offset_addr = imm_j;
        end
        OPC_JALR: begin
            exp.op1 = pc;
            exp.op2 = 64'd4;
            exp.reg_wen = 1'b1;
            exp.base_addr = r1;
            exp.offset_addr = imm_i;
        end
        OPC_LUI: begin
            exp.op2 = imm_u;
            exp.reg_wen = 1'b1;
        end
        OPC_AUIPC: begin
            exp.op1 = pc;
            exp.op2 = imm_u;
            exp.reg_wen = 1'b1;
            exp.offset_addr = imm_u;
        end
        default: ;
    endcase

    if (exp.reg_wen) begin // rd only carried when written
        exp.rd_addr = inst[11:7];
    end
    return exp;
endfunction

`endif

//--- verification/tb_decode_stage.sv
module tb_decode_stage import rv_decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    `include "decode_model.svh"

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int N_WB         = 32;          // x0 attempt plus x1..x31
    localparam int N_ALU        = 4 * 8 * 4;
    localparam int N_MEM        = 3 * 8 * 3;
    localparam int N_JUMP       = 4 * 8;
    localparam int N_ILLEGAL    = 16 + 17;
    localparam int N_RANDOM     = 300;
    localparam int N_TOTAL      = N_WB + N_ALU + N_MEM + N_JUMP + N_ILLEGAL + N_RANDOM;
    localparam int WATCHDOG_NS  = (2 * N_TOTAL + RESET_CYCLES) * CLK_PERIOD;

    logic      clk;
    logic      reset_i;
    logic      inst_valid_i;
    inst_t     inst_i;
    xlen_t     inst_addr_i;
    logic      wb_wen_i;
    reg_addr_t wb_addr_i;
    xlen_t     wb_data_i;
    logic      out_valid_o;
    id_ex_t    id_ex_o;

    xlen_t  shadow [32];    // mirror of every register written
    id_ex_t exp_q [$];      // one entry per outstanding strobe
    id_ex_t cur_exp;        // expectation for the current output pulse
    int     err_cnt     = 0;
    int     pass_cnt    = 0;
    int     fail_cnt    = 0;
    int     cycle_cnt   = 0;
    logic   seen_strobe = 1'b0;

    decode_stage DUT (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .wb_wen_i     (wb_wen_i),
        .wb_addr_i    (wb_addr_i),
        .wb_data_i    (wb_data_i),
        .out_valid_o  (out_valid_o),
        .id_ex_o      (id_ex_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (inst_valid_i) begin
            seen_strobe <= 1'b1;
        end
    end

    // take the next expectation while the output pulse is up
    always @(negedge clk) begin
        if (out_valid_o) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("output pulse at %0d ns with no instruction outstanding", $time);
            end else begin
                cur_exp = exp_q.pop_front();
            end
        end
    end

    a_idle_after_reset: assert property (@(posedge clk)
        (cycle_cnt > 0 && !seen_strobe) |-> (!out_valid_o && id_ex_o == '0))
        else begin
            err_cnt++;
            $display("[ERROR] %0d ns: output not idle and zero before the first strobe", $time);
        end

    a_strobe_follows: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_o == $past(inst_valid_i))
        else begin
            err_cnt++;
            $display("[ERROR] %0d ns: out_valid_o is not the strobe delayed by one cycle",
                $time);
        end

    a_bundle: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_o |-> (id_ex_o == cur_exp))
        else report_mismatch($sampled(id_ex_o), cur_exp);

    task automatic report_mismatch(id_ex_t got, id_ex_t exp);
        string fields;
        fields = "";
        if (got.inst != exp.inst)
            fields = {fields, " inst"};
        if (got.inst_addr != exp.inst_addr)
            fields = {fields, " inst_addr"};
        if (got.op1 != exp.op1)
            fields = {fields, " op1"};
        if (got.op2 != exp.op2)
            fields = {fields, " op2"};
        if (got.rd_addr != exp.rd_addr)
            fields = {fields, " rd_addr"};
        if (got.reg_wen != exp.reg_wen)
            fields = {fields, " reg_wen"};
        if (got.base_addr != exp.base_addr)
            fields = {fields, " base_addr"};
        if (got.offset_addr != exp.offset_addr)
            fields = {fields, " offset_addr"};
        err_cnt++;
        $display("[ERROR] %0d ns: id_ex_o wrong in%s for inst %h at pc %h",
            $time, fields, exp.inst, exp.inst_addr);
    endtask

    function automatic xlen_t rand_xlen();
        return {$urandom(), $urandom()};
    endfunction

    // random fields around a fixed opcode and func3
    function automatic inst_t rand_inst(logic [6:0] opc, logic [2:0] f3);
        inst_t inst;
        inst        = $urandom();
        inst[6:0]   = opc;
        inst[14:12] = f3;
        return inst;
    endfunction

    function automatic logic is_known_opcode(logic [6:0] opc);
        case (opc)
            OPC_OP_IMM, OPC_OP_IMM_W, OPC_OP, OPC_OP_W, OPC_BRANCH, OPC_LOAD,
            OPC_STORE, OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [6:0] pick_opcode(logic [3:0] sel);
        case (sel)
            4'd0:    return OPC_OP_IMM;
            4'd1:    return OPC_OP_IMM_W;
            4'd2:    return OPC_OP;
            4'd3:    return OPC_OP_W;
            4'd4:    return OPC_BRANCH;
            4'd5:    return OPC_LOAD;
            4'd6:    return OPC_STORE;
            4'd7:    return OPC_JALR;
            4'd8:    return OPC_LUI;
            4'd9:    return OPC_AUIPC;
            default: return OPC_JAL;
        endcase
    endfunction

    task automatic write_reg(reg_addr_t addr, xlen_t data);
        @(negedge clk);
        wb_wen_i  = 1'b1;
        wb_addr_i = addr;
        wb_data_i = data;
        if (addr != '0) begin
            shadow[addr] = data; // x0 keeps reading zero
        end
    endtask

    task automatic send(inst_t inst, xlen_t pc);
        @(negedge clk);
        inst_valid_i = 1'b1;
        inst_i       = inst;
        inst_addr_i  = pc;
        exp_q.push_back(decode_model(inst, pc, shadow));
    endtask

    // every func3 with x0 as both sources on the first pass
    task automatic sweep_func3(logic [6:0] opc, int reps);
        inst_t inst;
        for (int f = 0; f < 8; f++) begin
            for (int rep = 0; rep < reps; rep++) begin
                inst = rand_inst(opc, f[2:0]);
                if (rep == 0) begin
                    inst[19:15] = '0;
                    inst[24:20] = '0;
                end
                send(inst, rand_xlen());
            end
        end
    endtask

    task automatic drain();
        @(negedge clk);
        inst_valid_i = 1'b0;
        do begin
            @(posedge clk); // queue settles on the falling edge
        end while (exp_q.size() != 0);
        @(negedge clk);
    endtask

    task automatic finish_test(string name, int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int          errs;
        int unsigned rnd;
        logic [6:0]  opc;

        void'($urandom(32'hf8db6731));
        clk          = 1'b0;
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        wb_wen_i     = 1'b0;
        wb_addr_i    = '0;
        wb_data_i    = '0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end

        errs = err_cnt;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        repeat (5) @(negedge clk);
        finish_test("reset", errs);

        errs = err_cnt;
        write_reg(5'd0, rand_xlen());
        for (int r = 1; r < 32; r++) begin
            write_reg(r[4:0], rand_xlen());
        end
        @(negedge clk);
        wb_wen_i = 1'b0;
        sweep_func3(OPC_OP_IMM, 4);
        sweep_func3(OPC_OP_IMM_W, 4);
        sweep_func3(OPC_OP, 4);
        sweep_func3(OPC_OP_W, 4);
        drain();
        finish_test("alu", errs);

        errs = err_cnt;
        sweep_func3(OPC_BRANCH, 3);
        sweep_func3(OPC_LOAD, 3);
        sweep_func3(OPC_STORE, 3);
        drain();
        finish_test("branch load store", errs);

        errs = err_cnt;
        sweep_func3(OPC_JAL, 1);
        sweep_func3(OPC_JALR, 1);
        sweep_func3(OPC_LUI, 1);
        sweep_func3(OPC_AUIPC, 1);
        drain();
        finish_test("jal jalr lui auipc", errs);

        errs = err_cnt;
        for (int n = 0; n < 16; n++) begin
            do begin
                rnd = $urandom();
            end while (is_known_opcode(rnd[6:0]));
            send(rand_inst(rnd[6:0], rnd[14:12]), rand_xlen());
        end
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3 || f == 4 || f == 6 || f == 7) begin
                send(rand_inst(OPC_OP_IMM_W, f[2:0]), rand_xlen());
                send(rand_inst(OPC_OP_W, f[2:0]), rand_xlen());
            end
            if (f == 2 || f == 3) begin
                send(rand_inst(OPC_BRANCH, f[2:0]), rand_xlen());
            end
            if (f == 7) begin
                send(rand_inst(OPC_LOAD, f[2:0]), rand_xlen());
            end
            if (f >= 4) begin
                send(rand_inst(OPC_STORE, f[2:0]), rand_xlen());
            end
        end
        drain();
        finish_test("illegal", errs);

        errs = err_cnt;
        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = $urandom();
            if (rnd[1:0] != 2'b00) begin
                opc = pick_opcode(rnd[5:2] % 4'd11);
            end else begin
                opc = rnd[14:8]; // mostly unknown opcodes
            end
            send(rand_inst(opc, rnd[17:15]), rand_xlen());
        end
        drain();
        finish_test("random back-to-back", errs);

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
logic/rv_decode_pkg.sv
logic/inst_decoder.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/operand_select.sv
logic/id_ex_reg.sv
logic/decode_stage.sv
verification/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_decode_stage -Mdir obj_dir -f tb.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_decode_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
